/* bench/tb_decode_stage.sv */
`timescale 1ns/1ps

`include "decode_macros.svh"

module tb_decode_stage;
   import isa_pkg::*;
   import ctrl_pkg::*;

   localparam int MAX_WAIT   = 8;   // cycles allowed to reach id/ex
   localparam int NO_REDIR   = 0;
   localparam int BR_EQ      = 1;
   localparam int BR_NE      = 2;
   localparam int JMP_DIRECT = 3;
   localparam int JMP_REG    = 4;   // target from rs

   logic                i_clk;
   logic                i_rst;
   logic [`DATA_W-1:0]  i_pc;
   instr_u              i_instr;
   logic [`DATA_W-1:0]  i_wb_data;
   logic [`REG_AW-1:0]  i_wb_addr;
   logic                i_wb_wen;
   logic [`DATA_W-1:0]  o_ex_pc;
   logic [`DATA_W-1:0]  o_ex_rs_val;
   logic [`DATA_W-1:0]  o_ex_rt_val;
   logic [`DATA_W-1:0]  o_ex_imm;
   logic [`REG_AW-1:0]  o_ex_rs_num;
   logic [`REG_AW-1:0]  o_ex_rt_num;
   logic [`REG_AW-1:0]  o_ex_rd_num;
   logic [`FUNCT_W-1:0] o_ex_funct;
   alu_op_e             o_ex_alu_op;
   a_sel_e              o_ex_a_sel;
   b_sel_e              o_ex_b_sel;
   dest_sel_e           o_ex_dest_sel;
   logic                o_ex_mem_rd;
   logic                o_ex_mem_wr;
   logic                o_ex_wb_wen;
   logic                o_ex_wb_from_mem;
   logic [`DATA_W-1:0]  o_branch_addr;
   logic [`DATA_W-1:0]  o_jump_addr;
   logic                o_branch_taken;
   logic                o_pc_src;

   logic [`DATA_W-1:0]  model_regs [`NUM_REGS];   // expected register file contents
   integer              seed;
   int                  errors;
   bit                  timed_out;

   // stimulus table with one entry per instruction
   string               t_name [$];
   logic [31:0]         t_pc [$];
   logic [31:0]         t_instr [$];
   logic [31:0]         t_imm [$];
   alu_op_e             t_alu [$];
   a_sel_e              t_a [$];
   b_sel_e              t_b [$];
   dest_sel_e           t_dest [$];
   logic [1:0]          t_mem [$];    // {rd, wr}
   logic [1:0]          t_wb [$];     // {wen, from_mem}
   int                  t_redir [$];
   logic [31:0]         t_addr [$];   // branch or direct jump target

   decode_stage uut (.*);

   initial begin
      i_clk = 1'b0;
      forever #50 i_clk = ~i_clk;
   end

   function automatic logic [31:0] rtype_word(int rs, int rt, int rd, int shamt, funct_e fn);
      return {OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], shamt[4:0], fn};
   endfunction

   function automatic logic [31:0] itype_word(opcode_e op, int rs, int rt, int imm);
      return {op, rs[4:0], rt[4:0], imm[15:0]};
   endfunction

   function automatic logic [31:0] jump_word(opcode_e op, int index);
      return {op, index[25:0]};
   endfunction

   task automatic end_run;
      $display("Errors: %0d", errors);
      if (errors == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   endtask

   task automatic wait_edges(input int n);
      for (int c = 0; c < n; c++) @(posedge i_clk);
   endtask

   task automatic check_field(input string tname, input string field,
                              input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         $display("Mismatch %s %s: expected 0x%0h, actual 0x%0h", tname, field, exp, act);
         errors++;
      end
   endtask

   task automatic add_test(input string name, input logic [31:0] pc, input logic [31:0] instr,
                           input logic [31:0] imm, input alu_op_e alu, input a_sel_e a,
                           input b_sel_e b, input dest_sel_e dest, input logic [1:0] mem,
                           input logic [1:0] wb, input int redir, input logic [31:0] addr);
      t_name.push_back(name);
      t_pc.push_back(pc);
      t_instr.push_back(instr);
      t_imm.push_back(imm);
      t_alu.push_back(alu);
      t_a.push_back(a);
      t_b.push_back(b);
      t_dest.push_back(dest);
      t_mem.push_back(mem);
      t_wb.push_back(wb);
      t_redir.push_back(redir);
      t_addr.push_back(addr);
   endtask

   task automatic build_table;
      add_test("addi_neg", 32'hA000_0100, itype_word(OP_ADDI, 1, 3, -8), 32'hFFFF_FFF8,
               ALU_ADD, A_RS, B_IMM, DEST_RT, 2'b00, 2'b10, NO_REDIR, 32'h0);
      add_test("slti", 32'hA000_0104, itype_word(OP_SLTI, 2, 4, 'h10), 32'h0000_0010,
               ALU_SLT, A_RS, B_IMM, DEST_RT, 2'b00, 2'b10, NO_REDIR, 32'h0);
      add_test("andi", 32'hA000_0108, itype_word(OP_ANDI, 6, 5, 'h8001), 32'h0000_8001,
               ALU_AND, A_RS, B_IMM, DEST_RT, 2'b00, 2'b10, NO_REDIR, 32'h0);
      add_test("ori_r0", 32'hA000_010C, itype_word(OP_ORI, 0, 7, 'hFFFF), 32'h0000_FFFF,
               ALU_OR, A_RS, B_IMM, DEST_RT, 2'b00, 2'b10, NO_REDIR, 32'h0);
      add_test("xori", 32'hA000_0110, itype_word(OP_XORI, 9, 17, 'h1234), 32'h0000_1234,
               ALU_XOR, A_RS, B_IMM, DEST_RT, 2'b00, 2'b10, NO_REDIR, 32'h0);
      add_test("lui", 32'hA000_0114, itype_word(OP_LUI, 0, 10, 'hBEEF), 32'h0000_BEEF,
               ALU_LUI, A_NONE, B_IMM, DEST_RT, 2'b00, 2'b10, NO_REDIR, 32'h0);
      add_test("lw", 32'hA000_0118, itype_word(OP_LW, 12, 11, -4), 32'hFFFF_FFFC,
               ALU_ADD, A_RS, B_IMM, DEST_RT, 2'b10, 2'b11, NO_REDIR, 32'h0);
      add_test("sw", 32'hA000_011C, itype_word(OP_SW, 14, 13, 8), 32'h0000_0008,
               ALU_ADD, A_RS, B_IMM, DEST_RD, 2'b01, 2'b00, NO_REDIR, 32'h0);
      add_test("beq_same", 32'hA000_0120, itype_word(OP_BEQ, 5, 5, 3), 32'h0000_0003,
               ALU_NONE, A_NONE, B_IMM, DEST_RD, 2'b00, 2'b00, BR_EQ, 32'hA000_012C);
      add_test("beq_back", 32'hA000_0124, itype_word(OP_BEQ, 5, 6, -2), 32'hFFFF_FFFE,
               ALU_NONE, A_NONE, B_IMM, DEST_RD, 2'b00, 2'b00, BR_EQ, 32'hA000_011C);
      add_test("beq_r8_r9", 32'hA000_0128, itype_word(OP_BEQ, 8, 9, 'h100), 32'h0000_0100,
               ALU_NONE, A_NONE, B_IMM, DEST_RD, 2'b00, 2'b00, BR_EQ, 32'hA000_0528);
      add_test("bne_fwd", 32'hA000_012C, itype_word(OP_BNE, 5, 6, 16), 32'h0000_0010,
               ALU_NONE, A_NONE, B_IMM, DEST_RD, 2'b00, 2'b00, BR_NE, 32'hA000_016C);
      add_test("bne_back", 32'hA000_0130, itype_word(OP_BNE, 8, 9, -1), 32'hFFFF_FFFF,
               ALU_NONE, A_NONE, B_IMM, DEST_RD, 2'b00, 2'b00, BR_NE, 32'hA000_012C);
      add_test("j", 32'hA000_0134, jump_word(OP_J, 'h123456), 32'h0012_3456,
               ALU_NONE, A_NONE, B_IMM, DEST_RD, 2'b00, 2'b00, JMP_DIRECT, 32'hA048_D158);
      add_test("jal", 32'hA000_0138, jump_word(OP_JAL, 'h3FFFFFF), 32'h03FF_FFFF,
               ALU_JAL, A_PC, B_IMM, DEST_R31, 2'b00, 2'b10, JMP_DIRECT, 32'hAFFF_FFFC);
      add_test("add", 32'hA000_013C, rtype_word(1, 2, 15, 0, FN_ADD), 32'h0,
               ALU_FUNC, A_RS, B_RT, DEST_RD, 2'b00, 2'b10, NO_REDIR, 32'h0);
      add_test("sll", 32'hA000_0140, rtype_word(0, 3, 16, 7, FN_SLL), 32'h0000_0007,
               ALU_FUNC, A_SHAMT, B_RT, DEST_RD, 2'b00, 2'b10, NO_REDIR, 32'h0);
      add_test("jr", 32'hA000_0144, rtype_word(20, 0, 0, 0, FN_JR), 32'h0,
               ALU_FUNC, A_RS, B_RT, DEST_RD, 2'b00, 2'b00, JMP_REG, 32'h0);
      add_test("jalr", 32'hA000_0148, rtype_word(21, 0, 31, 0, FN_JALR), 32'h0,
               ALU_FUNC, A_PC, B_RT, DEST_RD, 2'b00, 2'b10, JMP_REG, 32'h0);
      add_test("nop", 32'hA000_014C, 32'h0, 32'h0,
               ALU_FUNC, A_SHAMT, B_RT, DEST_RD, 2'b00, 2'b00, NO_REDIR, 32'h0);
      // opcode 0x3f is not part of the isa
      add_test("unknown", 32'hA000_0150, 32'hFC00_1234, 32'h0000_1234,
               ALU_NONE, A_NONE, B_IMM, DEST_RD, 2'b00, 2'b00, NO_REDIR, 32'h0);
   endtask

   task automatic write_reg(input int addr, input logic [31:0] data);
      logic [4:0] a5;
      a5        = addr[4:0];
      i_wb_addr = a5;
      i_wb_data = data;
      i_wb_wen  = 1'b1;
      wait_edges(1);
      #5;
      if (a5 != 5'd0) model_regs[a5] = data;   // r0 keeps zero
   endtask

   task automatic check_reset;
      check_field("reset", "ex_pc", 32'h0, o_ex_pc);
      check_field("reset", "ex_rs_val", 32'h0, o_ex_rs_val);
      check_field("reset", "ex_rt_val", 32'h0, o_ex_rt_val);
      check_field("reset", "ex_imm", 32'h0, o_ex_imm);
      check_field("reset", "ex_rs_num", 32'h0, 32'(o_ex_rs_num));
      check_field("reset", "ex_rt_num", 32'h0, 32'(o_ex_rt_num));
      check_field("reset", "ex_rd_num", 32'h0, 32'(o_ex_rd_num));
      check_field("reset", "ex_funct", 32'h0, 32'(o_ex_funct));
      check_field("reset", "ex_alu_op", 32'h0, 32'(o_ex_alu_op));
      check_field("reset", "ex_a_sel", 32'h0, 32'(o_ex_a_sel));
      check_field("reset", "ex_b_sel", 32'h0, 32'(o_ex_b_sel));
      check_field("reset", "ex_dest_sel", 32'h0, 32'(o_ex_dest_sel));
      check_field("reset", "ex_mem_rd", 32'h0, 32'(o_ex_mem_rd));
      check_field("reset", "ex_mem_wr", 32'h0, 32'(o_ex_mem_wr));
      check_field("reset", "ex_wb_wen", 32'h0, 32'(o_ex_wb_wen));
      check_field("reset", "ex_wb_from_mem", 32'h0, 32'(o_ex_wb_from_mem));
   endtask

   // combinational outputs sampled mid-cycle
   task automatic check_redirect(input int k);
      instr_u      w;
      logic [31:0] rs_val;
      logic [31:0] rt_val;
      logic        exp_taken;
      w         = t_instr[k];
      rs_val    = model_regs[w.r_fmt.rs];
      rt_val    = model_regs[w.r_fmt.rt];
      exp_taken = (t_redir[k] == BR_EQ && rs_val == rt_val) ||
                  (t_redir[k] == BR_NE && rs_val != rt_val);
      check_field(t_name[k], "branch_taken", 32'(exp_taken), 32'(o_branch_taken));
      check_field(t_name[k], "pc_src", 32'(t_redir[k] >= JMP_DIRECT), 32'(o_pc_src));
      if (t_redir[k] == BR_EQ || t_redir[k] == BR_NE)
         check_field(t_name[k], "branch_addr", t_addr[k], o_branch_addr);
      if (t_redir[k] == JMP_DIRECT)
         check_field(t_name[k], "jump_addr", t_addr[k], o_jump_addr);
      if (t_redir[k] == JMP_REG)
         check_field(t_name[k], "jump_addr", rs_val, o_jump_addr);
   endtask

   task automatic wait_latch(input int k, output bit expired);
      int n;
      n       = 0;
      expired = 1'b0;
      do begin
         @(posedge i_clk);
         #1;
         n++;
      end while (o_ex_pc !== t_pc[k] && n < MAX_WAIT);
      if (o_ex_pc !== t_pc[k]) begin
         $display("%s: timeout, instruction never reached the ID/EX register", t_name[k]);
         errors++;
         expired = 1'b1;
      end else if (n != 1) begin
         $display("%s: ID/EX latency was %0d cycles instead of 1", t_name[k], n);
         errors++;
      end
   endtask

   task automatic check_latched(input int k);
      instr_u w;
      w = t_instr[k];
      check_field(t_name[k], "ex_pc", t_pc[k], o_ex_pc);
      check_field(t_name[k], "ex_rs_val", model_regs[w.r_fmt.rs], o_ex_rs_val);
      check_field(t_name[k], "ex_rt_val", model_regs[w.r_fmt.rt], o_ex_rt_val);
      check_field(t_name[k], "ex_imm", t_imm[k], o_ex_imm);
      check_field(t_name[k], "ex_rs_num", 32'(w.r_fmt.rs), 32'(o_ex_rs_num));
      check_field(t_name[k], "ex_rt_num", 32'(w.r_fmt.rt), 32'(o_ex_rt_num));
      check_field(t_name[k], "ex_rd_num", 32'(w.r_fmt.rd), 32'(o_ex_rd_num));
      check_field(t_name[k], "ex_funct", 32'(w.r_fmt.funct), 32'(o_ex_funct));
      check_field(t_name[k], "ex_alu_op", 32'(t_alu[k]), 32'(o_ex_alu_op));
      check_field(t_name[k], "ex_a_sel", 32'(t_a[k]), 32'(o_ex_a_sel));
      check_field(t_name[k], "ex_b_sel", 32'(t_b[k]), 32'(o_ex_b_sel));
      check_field(t_name[k], "ex_dest_sel", 32'(t_dest[k]), 32'(o_ex_dest_sel));
      check_field(t_name[k], "ex_mem_rd", 32'(t_mem[k][1]), 32'(o_ex_mem_rd));
      check_field(t_name[k], "ex_mem_wr", 32'(t_mem[k][0]), 32'(o_ex_mem_wr));
      check_field(t_name[k], "ex_wb_wen", 32'(t_wb[k][1]), 32'(o_ex_wb_wen));
      check_field(t_name[k], "ex_wb_from_mem", 32'(t_wb[k][0]), 32'(o_ex_wb_from_mem));
   endtask

   initial begin
      seed       = 32'hf7e3111e;
      errors     = 0;
      timed_out  = 1'b0;
      i_rst      = 1'b1;
      i_pc       = 32'h8000_0040;   // live inputs while reset is held
      i_instr    = itype_word(OP_LW, 5, 6, 'hABCD);
      i_wb_data  = '0;
      i_wb_addr  = '0;
      i_wb_wen   = 1'b0;
      model_regs = '{default: '0};
      build_table();

      wait_edges(2);
      #1;
      check_reset();
      #4;
      i_instr = itype_word(OP_SW, 7, 8, 'h5432);   // store decode in the last reset cycle
      wait_edges(1);
      #1;
      check_reset();
      #4;
      i_rst = 1'b0;

      // fill the register file through the write-back port
      for (int r = 0; r < `NUM_REGS; r++) write_reg(r, $random(seed));
      write_reg(9, model_regs[8]);   // equal operands in two registers
      i_wb_wen = 1'b0;

      for (int k = 0; k < t_name.size(); k++) begin
         i_pc    = t_pc[k];
         i_instr = t_instr[k];
         #45;
         check_redirect(k);
         wait_latch(k, timed_out);
         if (timed_out) begin
            break;
         end
         check_latched(k);
         #4;   // next instruction 5 ns after the edge
      end
      end_run();
   end

endmodule

/* common/ctrl_pkg.sv */
package ctrl_pkg;

   typedef enum logic [3:0] {
      ALU_NONE = 4'd0,
      ALU_ADD  = 4'd1,
      ALU_SLT  = 4'd2,
      ALU_AND  = 4'd3,
      ALU_OR   = 4'd4,
      ALU_XOR  = 4'd5,
      ALU_LUI  = 4'd6,
      ALU_JAL  = 4'd7,
      ALU_FUNC = 4'd8   // alu decodes funct itself
   } alu_op_e;

   // alu operand a source
   typedef enum logic [1:0] {
      A_PC    = 2'd0,
      A_RS    = 2'd1,
      A_SHAMT = 2'd2,
      A_NONE  = 2'd3
   } a_sel_e;

   typedef enum logic {
      B_RT  = 1'b0,
      B_IMM = 1'b1
   } b_sel_e;

   // write-back register number
   typedef enum logic [1:0] {
      DEST_RD  = 2'd0,
      DEST_RT  = 2'd1,
      DEST_R31 = 2'd2   // link register
   } dest_sel_e;

   typedef enum logic [1:0] {
      EXT_JUMP  = 2'd0,
      EXT_SIGN  = 2'd1,
      EXT_ZERO  = 2'd2,
      EXT_SHAMT = 2'd3
   } ext_sel_e;

   typedef struct packed {
      alu_op_e   alu_op;
      a_sel_e    a_sel;
      dest_sel_e dest_sel;
      b_sel_e    b_sel;
   } exec_ctrl_t;

   typedef struct packed {
      logic rd;
      logic wr;
   } mem_ctrl_t;

   typedef struct packed {
      logic wen;
      logic from_mem; // load result instead of alu result
   } wb_ctrl_t;

endpackage

/* common/decode_if.sv */
`timescale 1ns/1ps

interface decode_if;
   import ctrl_pkg::*;

   exec_ctrl_t exec;
   mem_ctrl_t  mem;
   wb_ctrl_t   wb;
   ext_sel_e   ext_sel;   // immediate extension mode
   logic       is_beq;
   logic       is_bne;
   logic       is_jump;   // j, jal, jr, jalr
   logic       jump_reg;  // target from rs

   // decoder side
   modport ctrl (
      output exec, mem, wb, ext_sel,
      output is_beq, is_bne, is_jump, jump_reg
   );

   // extender, redirect and id/ex side
   modport sink (
      input exec, mem, wb, ext_sel,
      input is_beq, is_bne, is_jump, jump_reg
   );

endinterface

/* common/decode_macros.svh */
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// datapath
`define DATA_W   32   // data and pc width
`define REG_AW   5    // register number width
`define NUM_REGS 32   // register file depth

// instruction fields
`define IMM_W    16   // i-type immediate
`define IDX_W    26   // j-type index
`define SHAMT_W  5    // r-type shift amount
`define OPC_W    6    // major opcode
`define FUNCT_W  6    // special function field

`endif

/* common/isa_pkg.sv */
package isa_pkg;

`include "decode_macros.svh"

   // r-type view, special opcode
   typedef struct packed {
      logic [`OPC_W-1:0]   opcode;
      logic [`REG_AW-1:0]  rs;
      logic [`REG_AW-1:0]  rt;
      logic [`REG_AW-1:0]  rd;
      logic [`SHAMT_W-1:0] shamt;
      logic [`FUNCT_W-1:0] funct;
   } r_fmt_t;

   // immediate, load/store and branch view
   typedef struct packed {
      logic [`OPC_W-1:0]  opcode;
      logic [`REG_AW-1:0] rs;
      logic [`REG_AW-1:0] rt;
      logic [`IMM_W-1:0]  imm16;
   } i_fmt_t;

   typedef struct packed {
      logic [`OPC_W-1:0] opcode;
      logic [`IDX_W-1:0] index26;
   } j_fmt_t;

   // one word, three ways to read it
   typedef union packed {
      r_fmt_t r_fmt;
      i_fmt_t i_fmt;
      j_fmt_t j_fmt;
   } instr_u;

   typedef enum logic [`OPC_W-1:0] {
      OP_SPECIAL = 6'h00,
      OP_J       = 6'h02,
      OP_JAL     = 6'h03,
      OP_BEQ     = 6'h04,
      OP_BNE     = 6'h05,
      OP_ADDI    = 6'h08,
      OP_SLTI    = 6'h0a,
      OP_ANDI    = 6'h0c,
      OP_ORI     = 6'h0d,
      OP_XORI    = 6'h0e,
      OP_LUI     = 6'h0f,
      OP_LW      = 6'h23,
      OP_SW      = 6'h2b
   } opcode_e;

   // special functions that change decode, the rest go to the alu as is
   typedef enum logic [`FUNCT_W-1:0] {
      FN_SLL  = 6'h00,
      FN_SRL  = 6'h02,
      FN_SRA  = 6'h03,
      FN_JR   = 6'h08,
      FN_JALR = 6'h09,
      FN_ADD  = 6'h20
   } funct_e;

endpackage

/* decode_ctrl/control_decoder.sv */
`timescale 1ns/1ps

module control_decoder (
   input  isa_pkg::instr_u i_instr,
   decode_if.ctrl          o_ctrl
);
   import isa_pkg::*;
   import ctrl_pkg::*;

   logic is_reg_jump;   // jr or jalr
   logic is_nop;

   assign is_reg_jump = (i_instr.r_fmt.funct == FN_JR) || (i_instr.r_fmt.funct == FN_JALR);
   assign is_nop      = (i_instr.r_fmt == '0); // sll r0,r0,0

   always_comb begin
      // bubble unless the opcode says otherwise
      o_ctrl.exec.alu_op   = ALU_NONE;
      o_ctrl.exec.a_sel    = A_NONE;
      o_ctrl.exec.dest_sel = DEST_RD;
      o_ctrl.exec.b_sel    = B_IMM;
      o_ctrl.mem           = '0;
      o_ctrl.wb            = '0;
      o_ctrl.ext_sel       = EXT_SIGN;
      o_ctrl.is_beq        = 1'b0;
      o_ctrl.is_bne        = 1'b0;
      o_ctrl.is_jump       = 1'b0;
      o_ctrl.jump_reg      = 1'b0;

      case (i_instr.r_fmt.opcode)
         OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
            o_ctrl.exec.a_sel    = A_RS;
            o_ctrl.exec.dest_sel = DEST_RT;
            o_ctrl.wb.wen        = 1'b1;
            case (i_instr.r_fmt.opcode)
               OP_ADDI: o_ctrl.exec.alu_op = ALU_ADD;
               OP_SLTI: o_ctrl.exec.alu_op = ALU_SLT;
               OP_ANDI: o_ctrl.exec.alu_op = ALU_AND;
               OP_ORI:  o_ctrl.exec.alu_op = ALU_OR;
               OP_XORI: o_ctrl.exec.alu_op = ALU_XOR;
               default: o_ctrl.exec.alu_op = ALU_LUI;
            endcase
            // logic ops take the immediate unsigned
            if (i_instr.r_fmt.opcode != OP_ADDI && i_instr.r_fmt.opcode != OP_SLTI) begin
               o_ctrl.ext_sel = EXT_ZERO;
            end
            if (i_instr.r_fmt.opcode == OP_LUI) begin
               o_ctrl.exec.a_sel = A_NONE;   // lui ignores rs
            end
         end
         OP_LW, OP_SW: begin
            o_ctrl.exec.alu_op = ALU_ADD;    // base + offset
            o_ctrl.exec.a_sel  = A_RS;
            if (i_instr.r_fmt.opcode == OP_LW) begin
               o_ctrl.exec.dest_sel = DEST_RT;
               o_ctrl.mem.rd        = 1'b1;
               o_ctrl.wb.wen        = 1'b1;
               o_ctrl.wb.from_mem   = 1'b1;
            end else begin
               o_ctrl.mem.wr = 1'b1;
            end
         end
         OP_BEQ: o_ctrl.is_beq = 1'b1;
         OP_BNE: o_ctrl.is_bne = 1'b1;
         OP_J: begin
            o_ctrl.ext_sel = EXT_JUMP;
            o_ctrl.is_jump = 1'b1;
         end
         OP_JAL: begin
            o_ctrl.ext_sel       = EXT_JUMP;
            o_ctrl.is_jump       = 1'b1;
            o_ctrl.exec.alu_op   = ALU_JAL;
            o_ctrl.exec.a_sel    = A_PC;      // return address from pc
            o_ctrl.exec.dest_sel = DEST_R31;
            o_ctrl.wb.wen        = 1'b1;
         end
         OP_SPECIAL: begin
            o_ctrl.ext_sel     = EXT_SHAMT;
            o_ctrl.exec.alu_op = ALU_FUNC;
            o_ctrl.exec.b_sel  = B_RT;
            case (i_instr.r_fmt.funct)
               FN_SLL, FN_SRL, FN_SRA: o_ctrl.exec.a_sel = A_SHAMT;
               FN_JALR:                o_ctrl.exec.a_sel = A_PC;
               default:                o_ctrl.exec.a_sel = A_RS;
            endcase
            o_ctrl.is_jump  = is_reg_jump;
            o_ctrl.jump_reg = is_reg_jump;
            o_ctrl.wb.wen   = !(i_instr.r_fmt.funct == FN_JR || is_nop);
         end
         default: ;   // unknown opcode stays a bubble
      endcase
   end

endmodule

/* decode_ctrl/imm_extender.sv */
`timescale 1ns/1ps

`include "decode_macros.svh"

module imm_extender (
   input  isa_pkg::instr_u    i_instr,
   decode_if.sink             i_ctrl,
   output logic [`DATA_W-1:0] o_imm
);
   import ctrl_pkg::*;

   logic [`IMM_W-1:0] imm16;

   assign imm16 = i_instr.i_fmt.imm16;

   always_comb begin
      case (i_ctrl.ext_sel)
         EXT_JUMP:  o_imm = {{(`DATA_W-`IDX_W){1'b0}}, i_instr.j_fmt.index26};
         EXT_SIGN:  o_imm = {{(`DATA_W-`IMM_W){imm16[`IMM_W-1]}}, imm16};
         EXT_ZERO:  o_imm = {{(`DATA_W-`IMM_W){1'b0}}, imm16};
         default:   o_imm = {{(`DATA_W-`SHAMT_W){1'b0}}, i_instr.r_fmt.shamt}; // shifts
      endcase
   end

endmodule

/* list.f */
+incdir+common
common/isa_pkg.sv
common/ctrl_pkg.sv
common/decode_if.sv
regfile/register_file.sv
decode_ctrl/control_decoder.sv
decode_ctrl/imm_extender.sv
rtl/pc_redirect.sv
rtl/id_ex_stage.sv
rtl/decode_stage.sv
bench/tb_decode_stage.sv

/* regfile/register_file.sv */
`timescale 1ns/1ps

`include "decode_macros.svh"

module register_file (
   input  logic               i_clk,
   input  logic               i_rst,
   input  logic [`REG_AW-1:0] i_rd_addr_a,
   input  logic [`REG_AW-1:0] i_rd_addr_b,
   input  logic [`REG_AW-1:0] i_wr_addr,
   input  logic [`DATA_W-1:0] i_wr_data,
   input  logic               i_wr_en,
   output logic [`DATA_W-1:0] o_rd_data_a,
   output logic [`DATA_W-1:0] o_rd_data_b
);

   logic [`DATA_W-1:0] regs [`NUM_REGS];
   logic               wr_ok;

   // r0 is hardwired, never written
   assign wr_ok = i_wr_en && (i_wr_addr != '0);

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_ok) begin
         regs[i_wr_addr] <= i_wr_data;
      end
   end

   // no write-through, a write shows up the cycle after
   assign o_rd_data_a = regs[i_rd_addr_a];
   assign o_rd_data_b = regs[i_rd_addr_b];

endmodule

/* rtl/decode_stage.sv */
`timescale 1ns/1ps

`include "decode_macros.svh"

module decode_stage (
   input  logic                 i_clk,
   input  logic                 i_rst,
   input  logic [`DATA_W-1:0]   i_pc,
   input  isa_pkg::instr_u      i_instr,
   input  logic [`DATA_W-1:0]   i_wb_data,
   input  logic [`REG_AW-1:0]   i_wb_addr,
   input  logic                 i_wb_wen,
   output logic [`DATA_W-1:0]   o_ex_pc,
   output logic [`DATA_W-1:0]   o_ex_rs_val,
   output logic [`DATA_W-1:0]   o_ex_rt_val,
   output logic [`DATA_W-1:0]   o_ex_imm,
   output logic [`REG_AW-1:0]   o_ex_rs_num,
   output logic [`REG_AW-1:0]   o_ex_rt_num,
   output logic [`REG_AW-1:0]   o_ex_rd_num,
   output logic [`FUNCT_W-1:0]  o_ex_funct,
   output ctrl_pkg::alu_op_e    o_ex_alu_op,
   output ctrl_pkg::a_sel_e     o_ex_a_sel,
   output ctrl_pkg::b_sel_e     o_ex_b_sel,
   output ctrl_pkg::dest_sel_e  o_ex_dest_sel,
   output logic                 o_ex_mem_rd,
   output logic                 o_ex_mem_wr,
   output logic                 o_ex_wb_wen,
   output logic                 o_ex_wb_from_mem,
   output logic [`DATA_W-1:0]   o_branch_addr,
   output logic [`DATA_W-1:0]   o_jump_addr,
   output logic                 o_branch_taken,
   output logic                 o_pc_src
);

   logic [`DATA_W-1:0] rs_val;
   logic [`DATA_W-1:0] rt_val;
   logic [`DATA_W-1:0] imm;

   decode_if u_ctrl_if ();

   register_file u_register_file (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_rd_addr_a (i_instr.r_fmt.rs),
      .i_rd_addr_b (i_instr.r_fmt.rt),
      .i_wr_addr   (i_wb_addr),   // from write-back stage
      .i_wr_data   (i_wb_data),
      .i_wr_en     (i_wb_wen),
      .o_rd_data_a (rs_val),
      .o_rd_data_b (rt_val)
   );

   control_decoder u_control_decoder (
      .i_instr (i_instr),
      .o_ctrl  (u_ctrl_if.ctrl)
   );

   imm_extender u_imm_extender (
      .i_instr (i_instr),
      .i_ctrl  (u_ctrl_if.sink),
      .o_imm   (imm)
   );

   pc_redirect u_pc_redirect (
      .i_pc           (i_pc),
      .i_rs_val       (rs_val),
      .i_rt_val       (rt_val),
      .i_imm          (imm),
      .i_ctrl         (u_ctrl_if.sink),
      .o_branch_addr  (o_branch_addr),
      .o_jump_addr    (o_jump_addr),
      .o_branch_taken (o_branch_taken),
      .o_pc_src       (o_pc_src)
   );

   id_ex_stage u_id_ex_stage (
      .i_clk            (i_clk),
      .i_rst            (i_rst),
      .i_pc             (i_pc),
      .i_rs_val         (rs_val),
      .i_rt_val         (rt_val),
      .i_imm            (imm),
      .i_instr          (i_instr),
      .i_ctrl           (u_ctrl_if.sink),
      .o_ex_pc          (o_ex_pc),
      .o_ex_rs_val      (o_ex_rs_val),
      .o_ex_rt_val      (o_ex_rt_val),
      .o_ex_imm         (o_ex_imm),
      .o_ex_rs_num      (o_ex_rs_num),
      .o_ex_rt_num      (o_ex_rt_num),
      .o_ex_rd_num      (o_ex_rd_num),
      .o_ex_funct       (o_ex_funct),
      .o_ex_alu_op      (o_ex_alu_op),
      .o_ex_a_sel       (o_ex_a_sel),
      .o_ex_b_sel       (o_ex_b_sel),
      .o_ex_dest_sel    (o_ex_dest_sel),
      .o_ex_mem_rd      (o_ex_mem_rd),
      .o_ex_mem_wr      (o_ex_mem_wr),
      .o_ex_wb_wen      (o_ex_wb_wen),
      .o_ex_wb_from_mem (o_ex_wb_from_mem)
   );

endmodule

/* rtl/id_ex_stage.sv */
`timescale 1ns/1ps

`include "decode_macros.svh"

module id_ex_stage (
   input  logic                 i_clk,
   input  logic                 i_rst,
   input  logic [`DATA_W-1:0]   i_pc,
   input  logic [`DATA_W-1:0]   i_rs_val,
   input  logic [`DATA_W-1:0]   i_rt_val,
   input  logic [`DATA_W-1:0]   i_imm,
   input  isa_pkg::instr_u      i_instr,
   decode_if.sink               i_ctrl,
   output logic [`DATA_W-1:0]   o_ex_pc,
   output logic [`DATA_W-1:0]   o_ex_rs_val,
   output logic [`DATA_W-1:0]   o_ex_rt_val,
   output logic [`DATA_W-1:0]   o_ex_imm,
   output logic [`REG_AW-1:0]   o_ex_rs_num,
   output logic [`REG_AW-1:0]   o_ex_rt_num,
   output logic [`REG_AW-1:0]   o_ex_rd_num,
   output logic [`FUNCT_W-1:0]  o_ex_funct,
   output ctrl_pkg::alu_op_e    o_ex_alu_op,
   output ctrl_pkg::a_sel_e     o_ex_a_sel,
   output ctrl_pkg::b_sel_e     o_ex_b_sel,
   output ctrl_pkg::dest_sel_e  o_ex_dest_sel,
   output logic                 o_ex_mem_rd,
   output logic                 o_ex_mem_wr,
   output logic                 o_ex_wb_wen,
   output logic                 o_ex_wb_from_mem
);
   import ctrl_pkg::*;

   exec_ctrl_t exec_q;
   mem_ctrl_t  mem_q;
   wb_ctrl_t   wb_q;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_ex_pc     <= '0;
         o_ex_rs_val <= '0;
         o_ex_rt_val <= '0;
         o_ex_imm    <= '0;
         o_ex_rs_num <= '0;
         o_ex_rt_num <= '0;
         o_ex_rd_num <= '0;
         o_ex_funct  <= '0;
         exec_q      <= '0;   // alu_op none
         mem_q       <= '0;
         wb_q        <= '0;
      end else begin
         o_ex_pc     <= i_pc;
         o_ex_rs_val <= i_rs_val;
         o_ex_rt_val <= i_rt_val;
         o_ex_imm    <= i_imm;
         o_ex_rs_num <= i_instr.r_fmt.rs;
         o_ex_rt_num <= i_instr.r_fmt.rt;
         o_ex_rd_num <= i_instr.r_fmt.rd;   // execute picks rd/rt/r31 by dest_sel
         o_ex_funct  <= i_instr.r_fmt.funct;
         exec_q      <= i_ctrl.exec;
         mem_q       <= i_ctrl.mem;
         wb_q        <= i_ctrl.wb;
      end
   end

   // unpack the control structs onto flat ports
   assign o_ex_alu_op      = exec_q.alu_op;
   assign o_ex_a_sel       = exec_q.a_sel;
   assign o_ex_b_sel       = exec_q.b_sel;
   assign o_ex_dest_sel    = exec_q.dest_sel;
   assign o_ex_mem_rd      = mem_q.rd;
   assign o_ex_mem_wr      = mem_q.wr;
   assign o_ex_wb_wen      = wb_q.wen;
   assign o_ex_wb_from_mem = wb_q.from_mem;

endmodule

/* rtl/pc_redirect.sv */
`timescale 1ns/1ps

`include "decode_macros.svh"

module pc_redirect (
   input  logic [`DATA_W-1:0] i_pc,
   input  logic [`DATA_W-1:0] i_rs_val,
   input  logic [`DATA_W-1:0] i_rt_val,
   input  logic [`DATA_W-1:0] i_imm,
   decode_if.sink             i_ctrl,
   output logic [`DATA_W-1:0] o_branch_addr,
   output logic [`DATA_W-1:0] o_jump_addr,
   output logic               o_branch_taken,
   output logic               o_pc_src
);

   logic                      ops_equal;
   logic [`DATA_W-1:0]        word_offset;
   logic [`DATA_W-1:0]        region_addr;

   assign ops_equal   = (i_rs_val == i_rt_val);
   assign word_offset = {i_imm[`DATA_W-3:0], 2'b00};  // sign already in i_imm

   // pseudo-direct target keeps the current 256 MB region
   assign region_addr = {i_pc[`DATA_W-1:`IDX_W+2], i_imm[`IDX_W-1:0], 2'b00};

   assign o_branch_addr  = i_pc + word_offset;
   assign o_jump_addr    = i_ctrl.jump_reg ? i_rs_val : region_addr;
   assign o_branch_taken = (i_ctrl.is_beq && ops_equal) || (i_ctrl.is_bne && !ops_equal);
   assign o_pc_src       = i_ctrl.is_jump;

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps --top-module tb_decode_stage \
   -f list.f -o tb_decode_stage
./obj_dir/tb_decode_stage > sim.log 2>&1
cat sim.log
if grep -q "Test failed" sim.log; then
   echo "simulation reported failure"
   exit 1
fi
echo "simulation finished without failure"
